// File: id_stage.f
+incdir+source
source/rv_isa_pkg.sv
source/id_stage_pkg.sv
source/id_insn_if.sv
source/id_issue_ctrl.sv
source/id_regfile.sv
source/id_insn_validator.sv
source/id_reg_usage.sv
source/id_branch_unit.sv
source/id_stage.sv
dv/tb_clock_gen.sv
dv/id_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the decode stage testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f id_stage.f --top-module id_stage_tb -o id_stage_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/id_stage_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
    exit 0
fi
exit 1

// File: dv/id_stage_tb.sv
// Directed testbench for the decode stage, run as the simulation top module.
`timescale 1ns/100ps

module id_stage_tb;

    // Several times the cycles the directed tests need.
    localparam int MAX_CYCLES = 400;

    logic clk, rst, stall, clear, d_valid, d_trap, wb_we, fw_rs1_bt;
    id_stage_pkg::pc_t      d_pc, q_pc, branch_target;
    id_stage_pkg::word_t    d_insn, wb_wdata, fw_val, q_insn, q_rs1_val, q_rs2_val;
    id_stage_pkg::cause_t   d_cause, q_cause;
    id_stage_pkg::reg_idx_t wb_rd;
    logic q_valid, q_use_rd, q_branch, q_branch_predict, q_trap;
    logic is_xret, is_jump, is_branch, branch_predict, use_rs1_bt;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    id_stage_pkg::word_t reg_vals [1:4];

    tb_clock_gen u_clock_gen (.clk(clk), .rst(rst));

    id_stage DUT (.*);

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Encoders for the base instruction formats.
    function automatic id_stage_pkg::word_t encode_r(logic [6:0] f7, id_stage_pkg::reg_idx_t rs2,
            id_stage_pkg::reg_idx_t rs1, logic [2:0] f3, id_stage_pkg::reg_idx_t rd,
            rv_isa_pkg::opcode_e op);
        return {f7, rs2, rs1, f3, rd, op, 2'b11};
    endfunction

    function automatic id_stage_pkg::word_t encode_i(id_stage_pkg::word_t imm,
            id_stage_pkg::reg_idx_t rs1, logic [2:0] f3, id_stage_pkg::reg_idx_t rd,
            rv_isa_pkg::opcode_e op);
        return {imm[11:0], rs1, f3, rd, op, 2'b11};
    endfunction

    function automatic id_stage_pkg::word_t encode_s(id_stage_pkg::word_t imm,
            id_stage_pkg::reg_idx_t rs2, id_stage_pkg::reg_idx_t rs1, logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_isa_pkg::STORE, 2'b11};
    endfunction

    function automatic id_stage_pkg::word_t encode_b(id_stage_pkg::word_t imm,
            id_stage_pkg::reg_idx_t rs2, id_stage_pkg::reg_idx_t rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::BRANCH, 2'b11};
    endfunction

    function automatic id_stage_pkg::word_t encode_j(id_stage_pkg::word_t imm,
            id_stage_pkg::reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::JAL, 2'b11};
    endfunction

    function automatic id_stage_pkg::word_t encode_u(logic [19:0] imm,
            id_stage_pkg::reg_idx_t rd, rv_isa_pkg::opcode_e op);
        return {imm, rd, op, 2'b11};
    endfunction

    // Target address as a halfword pc from base plus offset.
    function automatic id_stage_pkg::pc_t add_target(id_stage_pkg::word_t base,
            id_stage_pkg::word_t offset);
        id_stage_pkg::word_t sum;
        sum = base + offset;
        return sum[31:1];
    endfunction

    task automatic check_word(string name, id_stage_pkg::word_t exp, id_stage_pkg::word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_pc(string name, id_stage_pkg::pc_t exp, id_stage_pkg::pc_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_cause(string name, id_stage_pkg::cause_t exp, id_stage_pkg::cause_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // Present one fetched instruction and return on the falling edge after its capture.
    task automatic issue(id_stage_pkg::pc_t pc, id_stage_pkg::word_t insn);
        d_valid = 1'b1;
        d_trap  = 1'b0;
        d_pc    = pc;
        d_insn  = insn;
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic write_reg(id_stage_pkg::reg_idx_t rd, id_stage_pkg::word_t data);
        wb_we    = 1'b1;
        wb_rd    = rd;
        wb_wdata = data;
        @(posedge clk);
        @(negedge clk);
        wb_we = 1'b0;
    endtask

    task automatic test_reset();
        check_bit("reset q_valid", 1'b0, q_valid);
        check_bit("reset q_trap", 1'b0, q_trap);
        check_bit("reset is_jump", 1'b0, is_jump);
        check_bit("reset is_branch", 1'b0, is_branch);
        check_bit("reset is_xret", 1'b0, is_xret);
    endtask

    task automatic test_regfile();
        for (int i = 1; i <= 4; i++) begin
            reg_vals[i] = $urandom();
            write_reg(id_stage_pkg::reg_idx_t'(i), reg_vals[i]);
        end
        write_reg(5'd0, $urandom());
        issue(31'h40, encode_r(7'd0, 5'd2, 5'd1, 3'd0, 5'd5, rv_isa_pkg::OP));
        check_word("regfile x1", reg_vals[1], q_rs1_val);
        check_word("regfile x2", reg_vals[2], q_rs2_val);
        issue(31'h42, encode_r(7'd0, 5'd4, 5'd3, 3'd0, 5'd5, rv_isa_pkg::OP));
        check_word("regfile x3", reg_vals[3], q_rs1_val);
        check_word("regfile x4", reg_vals[4], q_rs2_val);
        issue(31'h44, encode_r(7'd0, 5'd0, 5'd0, 3'd0, 5'd5, rv_isa_pkg::OP));
        check_word("regfile x0 rs1", 32'd0, q_rs1_val);
        check_word("regfile x0 rs2", 32'd0, q_rs2_val);
    endtask

    task automatic test_validity();
        id_stage_pkg::word_t good [6];
        id_stage_pkg::word_t bad [2];
        good[0] = encode_r(7'd0, 5'd2, 5'd1, 3'd0, 5'd3, rv_isa_pkg::OP);
        good[1] = encode_r(7'd1, 5'd2, 5'd1, 3'd0, 5'd3, rv_isa_pkg::OP);
        good[2] = encode_i(32'd4, 5'd1, 3'd2, 5'd3, rv_isa_pkg::LOAD);
        good[3] = encode_s(32'd8, 5'd2, 5'd1, 3'd2);
        good[4] = encode_i(32'h305, 5'd1, 3'd1, 5'd0, rv_isa_pkg::SYSTEM);
        good[5] = 32'h0000_0073;
        // BRANCH funct3 2, and SLL with the alternate funct7.
        bad[0] = encode_b(32'd16, 5'd2, 5'd1, 3'd2);
        bad[1] = encode_r(7'b0100000, 5'd2, 5'd1, 3'd1, 5'd3, rv_isa_pkg::OP);
        for (int i = 0; i < 6; i++) begin
            issue(31'h80, good[i]);
            check_bit($sformatf("valid insn %0d q_valid", i), 1'b1, q_valid);
            check_bit($sformatf("valid insn %0d q_trap", i), 1'b0, q_trap);
        end
        for (int i = 0; i < 2; i++) begin
            issue(31'h90, bad[i]);
            check_bit($sformatf("bad insn %0d q_valid", i), 1'b0, q_valid);
            check_bit($sformatf("bad insn %0d q_trap", i), 1'b1, q_trap);
            check_cause($sformatf("bad insn %0d q_cause", i), 4'd2, q_cause);
        end
        // Fetch trap without a valid instruction.
        d_valid = 1'b0;
        d_trap  = 1'b1;
        d_cause = 4'd1;
        d_insn  = 32'h0000_0013;
        @(posedge clk);
        @(negedge clk);
        check_bit("fetch trap q_valid", 1'b0, q_valid);
        check_bit("fetch trap q_trap", 1'b1, q_trap);
        check_cause("fetch trap q_cause", 4'd1, q_cause);
        clear = 1'b1;
        issue(31'ha0, good[0]);
        check_bit("clear valid insn q_valid", 1'b0, q_valid);
        check_bit("clear valid insn q_trap", 1'b0, q_trap);
        issue(31'ha2, bad[0]);
        check_bit("clear bad insn q_valid", 1'b0, q_valid);
        check_bit("clear bad insn q_trap", 1'b0, q_trap);
        clear = 1'b0;
    endtask

    task automatic test_branch();
        id_stage_pkg::pc_t   pc;
        id_stage_pkg::word_t rs1v;
        pc = 31'h100;
        issue(pc, encode_j(-32'sd8, 5'd1));
        check_bit("jal is_jump", 1'b1, is_jump);
        check_bit("jal is_branch", 1'b0, is_branch);
        check_bit("jal branch_predict", 1'b1, branch_predict);
        check_pc("jal target", add_target({pc, 1'b0}, -32'sd8), branch_target);
        issue(pc, encode_b(32'h40, 5'd2, 5'd1, 3'd0));
        check_bit("beq is_branch", 1'b1, is_branch);
        check_bit("beq q_branch", 1'b1, q_branch);
        check_bit("beq is_jump", 1'b0, is_jump);
        check_bit("beq q_branch_predict", 1'b0, q_branch_predict);
        check_pc("beq target", add_target({pc, 1'b0}, 32'h40), branch_target);
        rs1v = $urandom();
        write_reg(5'd6, rs1v);
        issue(pc, encode_i(32'd12, 5'd6, 3'd0, 5'd1, rv_isa_pkg::JALR));
        check_bit("jalr use_rs1_bt", 1'b1, use_rs1_bt);
        check_pc("jalr target", add_target(rs1v, 32'd12), branch_target);
        fw_rs1_bt = 1'b1;
        fw_val    = $urandom();
        issue(pc, encode_i(32'd12, 5'd6, 3'd0, 5'd1, rv_isa_pkg::JALR));
        check_pc("jalr forwarded target", add_target(fw_val, 32'd12), branch_target);
        fw_rs1_bt = 1'b0;
        issue(pc, 32'h3020_0073);
        check_bit("mret is_xret", 1'b1, is_xret);
        check_bit("mret q_valid", 1'b1, q_valid);
    endtask

    task automatic test_stall_usage();
        id_stage_pkg::word_t held;
        id_stage_pkg::word_t insns [4];
        logic                exp_rd [4];
        held = encode_u(20'h12345, 5'd7, rv_isa_pkg::LUI);
        issue(31'h200, held);
        check_word("lui q_insn", held, q_insn);
        check_bit("lui q_use_rd", 1'b1, q_use_rd);
        stall = 1'b1;
        issue(31'h300, encode_s(32'd4, 5'd2, 5'd1, 3'd2));
        check_word("stall q_insn", held, q_insn);
        check_pc("stall q_pc", 31'h200, q_pc);
        stall = 1'b0;
        insns[0]  = encode_s(32'd4, 5'd2, 5'd1, 3'd2);
        exp_rd[0] = 1'b0;
        insns[1]  = encode_b(32'd8, 5'd2, 5'd1, 3'd1);
        exp_rd[1] = 1'b0;
        insns[2]  = encode_i(32'h300, 5'd0, 3'd2, 5'd3, rv_isa_pkg::SYSTEM);
        exp_rd[2] = 1'b1;
        insns[3]  = 32'h0000_0073;
        exp_rd[3] = 1'b0;
        for (int i = 0; i < 4; i++) begin
            issue(31'h310, insns[i]);
            check_bit($sformatf("usage insn %0d q_use_rd", i), exp_rd[i], q_use_rd);
        end
        check_bit("ecall is_xret", 1'b0, is_xret);
    endtask

    initial begin
        stall     = 1'b0;
        clear     = 1'b0;
        d_valid   = 1'b0;
        d_pc      = '0;
        d_insn    = '0;
        d_trap    = 1'b0;
        d_cause   = '0;
        wb_we     = 1'b0;
        wb_rd     = '0;
        wb_wdata  = '0;
        fw_rs1_bt = 1'b0;
        fw_val    = '0;
        void'($urandom(43));
        // Reset changes on a falling edge, so it is sampled on the rising one.
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
        end
        @(negedge clk);
        test_reset();
        test_regfile();
        test_validity();
        test_branch();
        test_stall_usage();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: dv/tb_clock_gen.sv
// Testbench clock and reset source for the decode stage testbench, 8 ns clock.
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    localparam time HALF_PERIOD = 4ns;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Reset held for four rising edges, released on a falling edge.
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: source/id_stage.sv
// Top level of the instruction decode stage, between fetch and execute.
`timescale 1ns/100ps

module id_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    input  logic                   clear,

    input  logic                   d_valid,
    input  id_stage_pkg::pc_t      d_pc,
    input  id_stage_pkg::word_t    d_insn,
    input  logic                   d_trap,
    input  id_stage_pkg::cause_t   d_cause,

    input  logic                   wb_we,
    input  id_stage_pkg::reg_idx_t wb_rd,
    input  id_stage_pkg::word_t    wb_wdata,

    input  logic                   fw_rs1_bt,
    input  id_stage_pkg::word_t    fw_val,

    output logic                   q_valid,
    output id_stage_pkg::pc_t      q_pc,
    output id_stage_pkg::word_t    q_insn,
    output logic                   q_use_rd,
    output id_stage_pkg::word_t    q_rs1_val,
    output id_stage_pkg::word_t    q_rs2_val,
    output logic                   q_branch,
    output logic                   q_branch_predict,
    output logic                   q_trap,
    output id_stage_pkg::cause_t   q_cause,

    output logic                   is_xret,
    output logic                   is_jump,
    output logic                   is_branch,
    output logic                   branch_predict,
    output id_stage_pkg::pc_t      branch_target,
    output logic                   use_rs1_bt
);

    logic insn_valid;

    id_insn_if insn_bus (.clk(clk));

    id_issue_ctrl u_issue_ctrl (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .clear      (clear),
        .d_valid    (d_valid),
        .d_pc       (d_pc),
        .d_insn     (d_insn),
        .d_trap     (d_trap),
        .d_cause    (d_cause),
        .insn_valid (insn_valid),
        .insn_bus   (insn_bus.issue),
        .q_valid    (q_valid),
        .q_trap     (q_trap),
        .q_cause    (q_cause)
    );

    // Read indices straight from the rs1 and rs2 fields.
    id_regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .we      (wb_we),
        .rd      (wb_rd),
        .wdata   (wb_wdata),
        .rs1     (insn_bus.insn[19:15]),
        .rs2     (insn_bus.insn[24:20]),
        .rs1_val (q_rs1_val),
        .rs2_val (q_rs2_val)
    );

    id_insn_validator u_validator (
        .insn_bus   (insn_bus.decode),
        .insn_valid (insn_valid)
    );

    id_reg_usage u_reg_usage (
        .insn_bus (insn_bus.decode),
        .use_rd   (q_use_rd)
    );

    id_branch_unit u_branch_unit (
        .insn_bus       (insn_bus.decode),
        .rs1_val        (q_rs1_val),
        .fw_rs1_bt      (fw_rs1_bt),
        .fw_val         (fw_val),
        .is_xret        (is_xret),
        .is_jump        (is_jump),
        .is_branch      (is_branch),
        .branch_predict (branch_predict),
        .branch_target  (branch_target),
        .use_rs1_bt     (use_rs1_bt)
    );

    assign q_pc             = insn_bus.pc;
    assign q_insn           = insn_bus.insn;
    assign q_branch         = is_branch;
    assign q_branch_predict = branch_predict;

endmodule

// File: source/id_branch_unit.sv
// Classifies jumps, branches and MRET and computes the branch target address.
`timescale 1ns/100ps
`include "id_settings.svh"

module id_branch_unit (
    id_insn_if.decode           insn_bus,
    input  id_stage_pkg::word_t rs1_val,
    input  logic                fw_rs1_bt,
    input  id_stage_pkg::word_t fw_val,
    output logic                is_xret,
    output logic                is_jump,
    output logic                is_branch,
    output logic                branch_predict,
    output id_stage_pkg::pc_t   branch_target,
    output logic                use_rs1_bt
);

    rv_isa_pkg::opcode_e opcode;
    id_stage_pkg::word_t insn;
    id_stage_pkg::word_t imm_i;
    id_stage_pkg::word_t imm_b;
    id_stage_pkg::word_t imm_j;
    id_stage_pkg::word_t add_lhs;
    id_stage_pkg::word_t add_rhs;
    id_stage_pkg::word_t add_res;

    assign insn   = insn_bus.insn;
    assign opcode = rv_isa_pkg::opcode_e'(insn[6:2]);

    // Sign-extended immediates.
    assign imm_i = {{20{insn[31]}}, insn[31:20]};
    assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
    assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};

    assign is_jump    = (opcode == rv_isa_pkg::JAL) || (opcode == rv_isa_pkg::JALR);
    assign is_branch  = (opcode == rv_isa_pkg::BRANCH);
    assign use_rs1_bt = (opcode == rv_isa_pkg::JALR);
    assign is_xret    = (opcode == rv_isa_pkg::SYSTEM) && (insn[14:12] == 3'b000)
                     && (insn[31:20] == 12'h302);

    // Backward branches have a negative offset and predict taken.
    assign branch_predict = insn[31];

    // JALR adds to rs1 or to its forwarded value.
    assign add_lhs = use_rs1_bt ? (fw_rs1_bt ? fw_val : rs1_val) : {insn_bus.pc, 1'b0};
    assign add_rhs = use_rs1_bt ? imm_i : (is_branch ? imm_b : imm_j);
    assign add_res = add_lhs + add_rhs;

    assign branch_target = add_res[`ID_XLEN-1:1];

    a_jump_branch_excl: assert property (
        @(posedge insn_bus.clk) !(is_jump && is_branch)
    );

endmodule

// File: source/id_reg_usage.sv
// Decodes whether the latched instruction writes its destination register.
`timescale 1ns/100ps

module id_reg_usage (
    id_insn_if.decode insn_bus,
    output logic      use_rd
);

    rv_isa_pkg::opcode_e opcode;
    logic [2:0]          funct3;

    assign opcode = rv_isa_pkg::opcode_e'(insn_bus.insn[6:2]);
    assign funct3 = insn_bus.insn[14:12];

    always_comb begin
        case (opcode)
            rv_isa_pkg::LOAD,
            rv_isa_pkg::OP_IMM,
            rv_isa_pkg::AUIPC,
            rv_isa_pkg::OP,
            rv_isa_pkg::LUI,
            rv_isa_pkg::JALR,
            rv_isa_pkg::JAL: begin
                use_rd = 1'b1;
            end
            rv_isa_pkg::SYSTEM: begin
                // Only CSR accesses return a value.
                use_rd = (funct3 != 3'b000);
            end
            default: begin
                use_rd = 1'b0;
            end
        endcase
    end

endmodule

// File: source/id_insn_validator.sv
// Checks that the latched instruction is a valid RV32IM or Zicsr encoding.
`timescale 1ns/100ps

module id_insn_validator (
    id_insn_if.decode insn_bus,
    output logic      insn_valid
);

    rv_isa_pkg::opcode_e opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic                valid_op_imm;
    logic                valid_op;
    logic                valid_system;

    assign opcode = rv_isa_pkg::opcode_e'(insn_bus.insn[6:2]);
    assign funct3 = insn_bus.insn[14:12];
    assign funct7 = insn_bus.insn[31:25];

    // Shift immediates carry funct7 in the upper bits.
    always_comb begin
        if (funct3 == rv_isa_pkg::SLL) begin
            valid_op_imm = (funct7 == 7'b0000000);
        end else if (funct3 == rv_isa_pkg::SRL) begin
            valid_op_imm = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        end else begin
            valid_op_imm = 1'b1;
        end
    end

    // Register ALU ops, the alternate form only exists for SUB and SRA.
    always_comb begin
        case (funct7)
            7'b0000000: valid_op = 1'b1;
            7'b0000001: valid_op = 1'b1;
            7'b0100000: valid_op = (funct3 == rv_isa_pkg::ADD) || (funct3 == rv_isa_pkg::SRL);
            default:    valid_op = 1'b0;
        endcase
    end

    // ECALL, EBREAK, MRET and WFI, or any CSR access.
    always_comb begin
        if (funct3 == 3'b000) begin
            case (insn_bus.insn[31:20])
                12'h000, 12'h001, 12'h302, 12'h105: valid_system = 1'b1;
                default:                            valid_system = 1'b0;
            endcase
        end else begin
            valid_system = (funct3 != 3'b100);
        end
    end

    always_comb begin
        if (insn_bus.insn[1:0] != 2'b11) begin
            // Compressed encodings are not supported.
            insn_valid = 1'b0;
        end else begin
            case (opcode)
                rv_isa_pkg::LOAD:     insn_valid = (funct3 != 3'b011) && (funct3 < 3'b110);
                rv_isa_pkg::STORE:    insn_valid = (funct3 <= 3'b010);
                rv_isa_pkg::MISC_MEM: insn_valid = (funct3[2:1] == 2'b00);
                rv_isa_pkg::OP_IMM:   insn_valid = valid_op_imm;
                rv_isa_pkg::OP:       insn_valid = valid_op;
                rv_isa_pkg::AUIPC:    insn_valid = 1'b1;
                rv_isa_pkg::LUI:      insn_valid = 1'b1;
                rv_isa_pkg::BRANCH:   insn_valid = funct3[2] || !funct3[1];
                rv_isa_pkg::JALR:     insn_valid = (funct3 == 3'b000);
                rv_isa_pkg::JAL:      insn_valid = 1'b1;
                rv_isa_pkg::SYSTEM:   insn_valid = valid_system;
                default:              insn_valid = 1'b0;
            endcase
        end
    end

endmodule

// File: source/id_regfile.sv
// Read-first register file with two read ports, one write port and x0 tied to zero.
`timescale 1ns/100ps
`include "id_settings.svh"

module id_regfile (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   we,
    input  id_stage_pkg::reg_idx_t rd,
    input  id_stage_pkg::word_t    wdata,
    input  id_stage_pkg::reg_idx_t rs1,
    input  id_stage_pkg::reg_idx_t rs2,
    output id_stage_pkg::word_t    rs1_val,
    output id_stage_pkg::word_t    rs2_val
);

    // Entry 0 is cleared on reset and never written.
    id_stage_pkg::word_t storage [0:`ID_NUM_REGS-1];

    assign rs1_val = storage[rs1];
    assign rs2_val = storage[rs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ID_NUM_REGS; i++) begin
                storage[i] <= '0;
            end
        end else if (we && rd != '0) begin
            storage[rd] <= wdata;
        end
    end

    // Writes to x0 must never leak into reads.
    a_x0_zero: assert property (
        @(posedge clk) disable iff (rst) (rs1 == '0) |-> (rs1_val == '0)
    );

endmodule

// File: source/id_issue_ctrl.sv
// IF/ID barrier register with stall, plus the valid, trap and cause outputs.
`timescale 1ns/100ps

module id_issue_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall,
    input  logic                 clear,

    input  logic                 d_valid,
    input  id_stage_pkg::pc_t    d_pc,
    input  id_stage_pkg::word_t  d_insn,
    input  logic                 d_trap,
    input  id_stage_pkg::cause_t d_cause,

    input  logic                 insn_valid,

    id_insn_if.issue             insn_bus,

    output logic                 q_valid,
    output logic                 q_trap,
    output id_stage_pkg::cause_t q_cause
);

    // Barrier register, holds while stalled.
    always_ff @(posedge clk) begin
        if (rst) begin
            insn_bus.valid <= 1'b0;
            insn_bus.trap  <= 1'b0;
            insn_bus.insn  <= '0;
        end else if (!stall) begin
            insn_bus.valid <= d_valid;
            insn_bus.pc    <= d_pc;
            insn_bus.insn  <= d_insn;
            insn_bus.trap  <= d_trap;
            insn_bus.cause <= d_cause;
        end
    end

    assign q_valid = insn_bus.valid && !clear && insn_valid;

    // Fetch trap wins, else a bad encoding becomes illegal-instruction.
    assign q_trap  = !clear && (insn_bus.trap || (insn_bus.valid && !insn_valid));
    assign q_cause = insn_bus.trap ? insn_bus.cause
                                   : id_stage_pkg::cause_t'(rv_isa_pkg::ILLEGAL_INSN);

    // Fetch never sends a valid instruction with a trap attached.
    a_valid_trap_excl: assert property (
        @(posedge clk) disable iff (rst) !(q_valid && q_trap)
    );

endmodule

// File: source/id_insn_if.sv
// Latched instruction bundle, from the barrier register to the decoders.
`timescale 1ns/100ps

interface id_insn_if (
    input logic clk
);
    logic                 valid;
    id_stage_pkg::pc_t    pc;
    id_stage_pkg::word_t  insn;
    logic                 trap;
    id_stage_pkg::cause_t cause;

    // Barrier side.
    modport issue (
        output valid, pc, insn, trap, cause
    );

    // Decoder side, clock only for checks.
    modport decode (
        input clk, pc, insn
    );

endinterface

// File: source/id_stage_pkg.sv
// Data types of the decode stage, shared by its RTL and testbench.
`include "id_settings.svh"

package id_stage_pkg;

    // One data word.
    typedef logic [`ID_XLEN-1:0] word_t;

    // Instruction address, bit 0 is always zero and not stored.
    typedef logic [`ID_XLEN-1:1] pc_t;

    // Register index.
    typedef logic [`ID_REG_IDX_W-1:0] reg_idx_t;

    // Trap cause code.
    typedef logic [`ID_CAUSE_W-1:0] cause_t;

endpackage

// File: source/rv_isa_pkg.sv
// RISC-V instruction encodings used by the decode logic and its testbench.
`include "id_settings.svh"

package rv_isa_pkg;

    // Major opcodes, instruction bits 6 to 2.
    typedef enum logic [4:0] {
        LOAD     = 5'b00000,
        MISC_MEM = 5'b00011,
        OP_IMM   = 5'b00100,
        AUIPC    = 5'b00101,
        STORE    = 5'b01000,
        OP       = 5'b01100,
        LUI      = 5'b01101,
        BRANCH   = 5'b11000,
        JALR     = 5'b11001,
        JAL      = 5'b11011,
        SYSTEM   = 5'b11100
    } opcode_e;

    // ALU funct3 values that need extra funct7 checks.
    typedef enum logic [2:0] {
        ADD = 3'b000,
        SLL = 3'b001,
        SRL = 3'b101
    } funct3_alu_e;

    // Trap causes raised by this stage.
    typedef enum logic [`ID_CAUSE_W-1:0] {
        ILLEGAL_INSN = 4'd2
    } cause_e;

endpackage

// File: source/id_settings.svh
// Width and size defines shared by the decode stage packages and RTL.
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// Data word width.
`define ID_XLEN 32

// Number of architectural registers, x0 included.
`define ID_NUM_REGS 32

// Register index width.
`define ID_REG_IDX_W 5

// Trap cause width.
`define ID_CAUSE_W 4

`endif
